// ==== common/main_pkg.sv ====
// Memory map, bus region and I/O register encodings for the main CPU subsystem and its testbench
package main_pkg;

    // Work RAM sizing, 4 KB
    localparam int ram_aw = 12;

    // Address pages used by the decoder
    localparam logic [7:0] io_page   = 8'h00;
    localparam logic [7:0] pal_page  = 8'h0C;
    localparam logic [3:0] ram_page  = 4'h1;
    localparam logic [2:0] gfx1_page = 3'd1;
    localparam logic [2:0] gfx2_page = 3'd2;
    localparam logic [2:0] bank_page = 3'd3;

    // ROM banking, 8 KB window at 0x6000
    localparam int rom_bank_w = 3;
    localparam logic [16:0] fixed_rom_base = 17'h10000;

    // Unmapped reads float high
    localparam logic [7:0] open_bus = 8'hFF;

    typedef enum logic [2:0] {
        reg_none,
        reg_io,
        reg_pal,
        reg_ram,
        reg_gfx1,
        reg_gfx2,
        reg_bank,
        reg_fixed
    } region_e;

    // Offsets inside the I/O page
    typedef enum logic [7:0] {
        io_coin      = 8'h10,
        io_joy1      = 8'h11,
        io_joy2      = 8'h12,
        io_dsw_a     = 8'h14,
        io_dsw_b     = 8'h15,
        io_dsw_c     = 8'h16,
        io_snd_irq   = 8'h18,
        io_snd_latch = 8'h1A,
        io_rom_bank  = 8'h1C
    } io_reg_e;

endpackage

// ==== common/cpu_bus_if.sv ====
// CPU bus bundle shared by the decoder, work RAM and read multiplexer
`timescale 1ns/1ps

interface cpu_bus_if;
    logic [15:0] addr;
    logic        rnw;
    logic        vma;
    logic [ 7:0] dout;
    logic        cen;

    modport decoder (
        input addr,
        input rnw,
        input vma,
        input dout,
        input cen
    );

    // vma reaches these blocks through ram_cs and region
    modport work_ram (
        input addr,
        input rnw,
        input dout,
        input cen
    );

    modport busmux (
        input addr,
        input rnw,
        input dout,
        input cen
    );
endinterface

// ==== source/main_irq.sv ====
// Graphics IRQ and NMI edge latches for the main CPU, gated by pause and cleared on acknowledge
`timescale 1ns/1ps

module main_irq (
    input  logic clk,
    input  logic rst,
    input  logic gfx_irqn,
    input  logic gfx_nmin,
    input  logic dip_pause,
    input  logic irq_ack,
    output logic irq_n,
    output logic nmi_n
);

    // Bit 0 is the IRQ path, bit 1 the NMI path
    logic [1:0] trig;
    logic [1:0] trig_q;
    logic [1:0] flag;

    // Paused game holds both requests off
    assign trig = {~gfx_nmin & dip_pause, ~gfx_irqn & dip_pause};

    always_ff @(posedge clk) begin
        if (rst) begin
            trig_q <= 2'b00;
            flag   <= 2'b00;
        end else begin
            trig_q <= trig;
            for (int i = 0; i < 2; i++) begin
                // A new edge beats a pending acknowledge
                if (trig[i] && !trig_q[i]) begin
                    flag[i] <= 1'b1;
                end else if (irq_ack) begin
                    flag[i] <= 1'b0;
                end
            end
        end
    end

    assign irq_n = ~flag[0];
    assign nmi_n = ~flag[1];

endmodule

// ==== main_decoder/main_decoder.sv ====
// Main CPU address decoder with chip selects, ROM bank register and banked ROM address
`timescale 1ns/1ps

module main_decoder
    import main_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    cpu_bus_if.decoder   bus,
    input  logic         rom_ok,
    output region_e      region,
    output logic         ram_cs,
    output logic         gfx1_cs,
    output logic         gfx2_cs,
    output logic         pal_cs,
    output logic         rom_cs,
    output logic         cpu_wait,
    output logic [16:0]  rom_addr
);

    logic [rom_bank_w-1:0] rom_bank;
    logic                  bank_we;

    // Larger windows first, the I/O and palette pages sit inside the low 4 KB
    always_comb begin
        if (!bus.vma) begin
            region = reg_none;
        end else if (bus.addr[15]) begin
            region = reg_fixed;
        end else if (bus.addr[15:13] == bank_page) begin
            region = reg_bank;
        end else if (bus.addr[15:13] == gfx2_page) begin
            region = reg_gfx2;
        end else if (bus.addr[15:13] == gfx1_page) begin
            region = reg_gfx1;
        end else if (bus.addr[15:12] == ram_page) begin
            region = reg_ram;
        end else if (bus.addr[15:8] == pal_page) begin
            region = reg_pal;
        end else if (bus.addr[15:8] == io_page) begin
            region = reg_io;
        end else begin
            region = reg_none;
        end
    end

    assign ram_cs   = region == reg_ram;
    assign gfx1_cs  = region == reg_gfx1;
    assign gfx2_cs  = region == reg_gfx2;
    assign pal_cs   = region == reg_pal;
    assign rom_cs   = region == reg_bank || region == reg_fixed;

    // CPU stalls until the ROM fetch is ready
    assign cpu_wait = rom_cs & ~rom_ok;

    assign bank_we = region == reg_io && bus.cen && !bus.rnw &&
                     bus.addr[7:0] == io_rom_bank;

    always_ff @(posedge clk) begin
        if (rst) begin
            rom_bank <= '0;
        end else if (bank_we) begin
            rom_bank <= bus.dout[rom_bank_w-1:0];
        end
    end

    // Banked window sits below the fixed 32 KB in the ROM image
    always_comb begin
        if (bus.addr[15]) begin
            rom_addr = fixed_rom_base + {2'b00, bus.addr[14:0]};
        end else begin
            rom_addr = {1'b0, rom_bank, bus.addr[12:0]};
        end
    end

endmodule

// ==== source/work_ram.sv ====
// Main CPU work RAM, single port, synchronous read, written on CPU clock enable
`timescale 1ns/1ps

module work_ram
    import main_pkg::*;
(
    input  logic         clk,
    cpu_bus_if.work_ram  bus,
    input  logic         ram_cs,
    output logic [7:0]   ram_dout
);

    logic [7:0] mem [0:2**ram_aw-1];
    logic       we;

    assign we = ram_cs && bus.cen && !bus.rnw;

    // Read returns the old byte on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[bus.addr[ram_aw-1:0]] <= bus.dout;
        end
        ram_dout <= mem[bus.addr[ram_aw-1:0]];
    end

endmodule

// ==== source/main_busmux.sv ====
// Main CPU read data multiplexer with cabinet input mapping and the sound CPU latch
`timescale 1ns/1ps

module main_busmux
    import main_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    cpu_bus_if.busmux    bus,
    input  region_e      region,
    input  logic [7:0]   ram_dout,
    input  logic [7:0]   rom_data,
    input  logic [7:0]   gfx1_dout,
    input  logic [7:0]   gfx2_dout,
    input  logic [7:0]   pal_dout,
    input  logic [1:0]   start_button,
    input  logic [1:0]   coin_input,
    input  logic [5:0]   joystick1,
    input  logic [5:0]   joystick2,
    input  logic         service,
    input  logic [7:0]   dipsw_a,
    input  logic [7:0]   dipsw_b,
    input  logic [3:0]   dipsw_c,
    output logic [7:0]   cpu_din,
    output logic [7:0]   snd_latch,
    output logic         snd_irq
);

    logic [7:0] rd_mux;
    logic [7:0] din_q;
    logic       ram_sel_q;
    logic       io_wr;

    assign io_wr = region == reg_io && bus.cen && !bus.rnw;

    always_comb begin
        rd_mux = open_bus;
        case (region)
            reg_io: begin
                case (bus.addr[7:0])
                    io_coin:  rd_mux = {2'b11, start_button, 2'b11, coin_input};
                    io_joy1:  rd_mux = {2'b11, joystick1};
                    io_joy2:  rd_mux = {2'b11, joystick2};
                    io_dsw_a: rd_mux = dipsw_a;
                    io_dsw_b: rd_mux = dipsw_b;
                    io_dsw_c: rd_mux = {3'b111, service, dipsw_c};
                    default:  rd_mux = open_bus;
                endcase
            end
            reg_pal:   rd_mux = pal_dout;
            reg_gfx1:  rd_mux = gfx1_dout;
            reg_gfx2:  rd_mux = gfx2_dout;
            reg_bank:  rd_mux = rom_data;
            reg_fixed: rd_mux = rom_data;
            default:   rd_mux = open_bus;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            din_q     <= open_bus;
            ram_sel_q <= 1'b0;
        end else begin
            din_q     <= rd_mux;
            ram_sel_q <= region == reg_ram;
        end
    end

    // RAM output is already registered, so it bypasses din_q
    assign cpu_din = ram_sel_q ? ram_dout : din_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            snd_latch <= 8'h00;
            snd_irq   <= 1'b0;
        end else begin
            snd_irq <= io_wr && bus.addr[7:0] == io_snd_irq;
            if (io_wr && bus.addr[7:0] == io_snd_latch) begin
                snd_latch <= bus.dout;
            end
        end
    end

endmodule

// ==== source/main_board.sv ====
// Main CPU bus subsystem top level, connects the external 6809 bus to decode, RAM and read mux
`timescale 1ns/1ps

module main_board
    import main_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         cpu_cen,
    input  logic [15:0]  cpu_addr,
    input  logic         cpu_rnw,
    input  logic         cpu_vma,
    input  logic [ 7:0]  cpu_dout,
    input  logic         irq_ack,
    input  logic [ 7:0]  rom_data,
    input  logic         rom_ok,
    input  logic         gfx_irqn,
    input  logic         gfx_nmin,
    input  logic [ 7:0]  gfx1_dout,
    input  logic [ 7:0]  gfx2_dout,
    input  logic [ 7:0]  pal_dout,
    input  logic         dip_pause,
    input  logic [ 1:0]  start_button,
    input  logic [ 1:0]  coin_input,
    input  logic [ 5:0]  joystick1,
    input  logic [ 5:0]  joystick2,
    input  logic         service,
    input  logic [ 7:0]  dipsw_a,
    input  logic [ 7:0]  dipsw_b,
    input  logic [ 3:0]  dipsw_c,
    output logic [ 7:0]  cpu_din,
    output logic         irq_n,
    output logic         nmi_n,
    output logic         cpu_wait,
    output logic [16:0]  rom_addr,
    output logic         rom_cs,
    output logic         gfx1_cs,
    output logic         gfx2_cs,
    output logic         pal_cs,
    output logic         snd_irq,
    output logic [ 7:0]  snd_latch
);

    region_e    region;
    logic       ram_cs;
    logic [7:0] ram_dout;

    cpu_bus_if u_bus ();

    assign u_bus.addr = cpu_addr;
    assign u_bus.rnw  = cpu_rnw;
    assign u_bus.vma  = cpu_vma;
    assign u_bus.dout = cpu_dout;
    assign u_bus.cen  = cpu_cen;

    main_irq u_irq (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .gfx_irqn  ( gfx_irqn  ),
        .gfx_nmin  ( gfx_nmin  ),
        .dip_pause ( dip_pause ),
        .irq_ack   ( irq_ack   ),
        .irq_n     ( irq_n     ),
        .nmi_n     ( nmi_n     )
    );

    main_decoder u_decoder (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .bus      ( u_bus    ),
        .rom_ok   ( rom_ok   ),
        .region   ( region   ),
        .ram_cs   ( ram_cs   ),
        .gfx1_cs  ( gfx1_cs  ),
        .gfx2_cs  ( gfx2_cs  ),
        .pal_cs   ( pal_cs   ),
        .rom_cs   ( rom_cs   ),
        .cpu_wait ( cpu_wait ),
        .rom_addr ( rom_addr )
    );

    work_ram u_ram (
        .clk      ( clk      ),
        .bus      ( u_bus    ),
        .ram_cs   ( ram_cs   ),
        .ram_dout ( ram_dout )
    );

    main_busmux u_busmux (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .bus          ( u_bus        ),
        .region       ( region       ),
        .ram_dout     ( ram_dout     ),
        .rom_data     ( rom_data     ),
        .gfx1_dout    ( gfx1_dout    ),
        .gfx2_dout    ( gfx2_dout    ),
        .pal_dout     ( pal_dout     ),
        .start_button ( start_button ),
        .coin_input   ( coin_input   ),
        .joystick1    ( joystick1    ),
        .joystick2    ( joystick2    ),
        .service      ( service      ),
        .dipsw_a      ( dipsw_a      ),
        .dipsw_b      ( dipsw_b      ),
        .dipsw_c      ( dipsw_c      ),
        .cpu_din      ( cpu_din      ),
        .snd_latch    ( snd_latch    ),
        .snd_irq      ( snd_irq      )
    );

endmodule

// ==== dv/tb_main_board.sv ====
// Testbench for the main CPU bus subsystem that drives bus cycles into main_board and checks the responses
`timescale 1ns/1ps

module tb_main_board
    import main_pkg::*;
();

    localparam int n_ram   = 24;
    localparam int n_tests = 2 * n_ram + 30;

    logic        clk;
    logic        rst;
    logic        cpu_cen;
    logic [15:0] cpu_addr;
    logic        cpu_rnw;
    logic        cpu_vma;
    logic [ 7:0] cpu_dout;
    logic        irq_ack;
    logic [ 7:0] rom_data;
    logic        rom_ok;
    logic        gfx_irqn;
    logic        gfx_nmin;
    logic [ 7:0] gfx1_dout;
    logic [ 7:0] gfx2_dout;
    logic [ 7:0] pal_dout;
    logic        dip_pause;
    logic [ 1:0] start_button;
    logic [ 1:0] coin_input;
    logic [ 5:0] joystick1;
    logic [ 5:0] joystick2;
    logic        service;
    logic [ 7:0] dipsw_a;
    logic [ 7:0] dipsw_b;
    logic [ 3:0] dipsw_c;
    logic [ 7:0] cpu_din;
    logic        irq_n;
    logic        nmi_n;
    logic        cpu_wait;
    logic [16:0] rom_addr;
    logic        rom_cs;
    logic        gfx1_cs;
    logic        gfx2_cs;
    logic        pal_cs;
    logic        snd_irq;
    logic [ 7:0] snd_latch;

    int          checks;
    int          errors;
    logic [31:0] lfsr;
    logic [ 7:0] ram_model [0:2**ram_aw-1];
    logic [ram_aw-1:0] ram_addrs [$];

    main_board i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return val;
    endfunction

    task automatic value_fail(input string name, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic event_fail(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else value_fail(name, got, exp);
    endtask

    // Four clk cycles per access with cen only in the last one
    task automatic bus_access(input logic [15:0] addr, input logic rnw, input logic [7:0] wdata,
                              output logic [7:0] rdata, output logic [3:0] sel);
        cpu_addr = addr;
        cpu_rnw  = rnw;
        cpu_dout = wdata;
        cpu_vma  = 1'b1;
        cpu_cen  = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        cpu_cen = 1'b1;
        @(posedge clk);
        #1;
        rdata   = cpu_din;
        sel     = {rom_cs, gfx1_cs, gfx2_cs, pal_cs};
        cpu_cen = 1'b0;
        cpu_vma = 1'b0;
        cpu_rnw = 1'b1;
    endtask

    task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] din;
        logic [3:0] sel;
        bus_access(addr, 1'b0, data, din, sel);
    endtask

    task automatic read_expect(input string name, input logic [15:0] addr,
                               input logic [7:0] exp_din, input logic [3:0] exp_sel);
        logic [7:0] din;
        logic [3:0] sel;
        bus_access(addr, 1'b1, 8'h00, din, sel);
        check(name, 32'(din), 32'(exp_din));
        check("chip selects", 32'(sel), 32'(exp_sel));
    endtask

    // CPU side holds cen low while the ROM is not ready
    task automatic rom_read(input logic [15:0] addr, input logic [31:0] exp_addr);
        logic [7:0] data;
        int         wait_cycles;
        cpu_addr = addr;
        cpu_rnw  = 1'b1;
        cpu_vma  = 1'b1;
        rom_ok   = 1'b0;
        @(posedge clk);
        #1;
        check("cpu_wait", 32'(cpu_wait), 32'h1);
        check("rom_addr", 32'(rom_addr), exp_addr);
        data        = 8'(rand_bits(8));
        rom_data    = data;
        rom_ok      = 1'b1;
        wait_cycles = 0;
        do begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end while (cpu_wait && wait_cycles < 16);
        if (cpu_wait) begin
            event_fail("cpu_wait stayed high after rom_ok rose");
        end
        read_expect("cpu_din rom", addr, data, 4'b1000);
    endtask

    task automatic edge_latch_case(input bit nmi);
        string name;
        name = nmi ? "nmi_n" : "irq_n";
        if (nmi) gfx_nmin = 1'b0;
        else gfx_irqn = 1'b0;
        @(posedge clk);
        #1;
        check(name, 32'(nmi ? nmi_n : irq_n), 32'h0);
        if (nmi) gfx_nmin = 1'b1;
        else gfx_irqn = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        check(name, 32'(nmi ? nmi_n : irq_n), 32'h0);
        irq_ack = 1'b1;
        @(posedge clk);
        #1;
        irq_ack = 1'b0;
        check(name, 32'(nmi ? nmi_n : irq_n), 32'h1);
    endtask

    // ROM spans the banked and fixed windows from 0x6000 up
    assert property (@(posedge clk)
        cpu_wait == (cpu_vma && cpu_addr >= 16'h6000 && !rom_ok))
        else value_fail("cpu_wait", 32'($sampled(cpu_wait)),
                        32'($sampled(cpu_vma && cpu_addr >= 16'h6000 && !rom_ok)));
    assert property (@(posedge clk) disable iff (rst) snd_irq |=> !snd_irq)
        else event_fail("snd_irq stayed high for more than one cycle");
    assert property (@(posedge clk) disable iff (rst) (!irq_n && !irq_ack) |=> !irq_n)
        else event_fail("irq_n released without irq_ack");
    assert property (@(posedge clk) disable iff (rst) (!nmi_n && !irq_ack) |=> !nmi_n)
        else event_fail("nmi_n released without irq_ack");
    assert property (@(posedge clk) disable iff (rst) (irq_n && !dip_pause) |=> irq_n)
        else event_fail("irq_n fell while paused");
    assert property (@(posedge clk) disable iff (rst) (nmi_n && !dip_pause) |=> nmi_n)
        else event_fail("nmi_n fell while paused");

    initial begin
        repeat (n_tests * 40 + 100) @(posedge clk);
        $display("Timeout: the run did not finish in time");
        $display("test failed");
        $finish;
    end

    initial begin
        logic [2:0]  bank;
        logic [15:0] off;
        logic [7:0]  data;
        checks       = 0;
        errors       = 0;
        lfsr         = 32'h7367_fef1;
        rst          = 1'b1;
        cpu_cen      = 1'b0;
        cpu_addr     = 16'h6123;
        cpu_rnw      = 1'b1;
        cpu_vma      = 1'b0;
        cpu_dout     = 8'h00;
        irq_ack      = 1'b0;
        rom_data     = 8'h00;
        rom_ok       = 1'b1;
        gfx_irqn     = 1'b1;
        gfx_nmin     = 1'b1;
        gfx1_dout    = 8'h00;
        gfx2_dout    = 8'h00;
        pal_dout     = 8'h00;
        dip_pause    = 1'b1;
        start_button = 2'b11;
        coin_input   = 2'b11;
        joystick1    = 6'h3F;
        joystick2    = 6'h3F;
        service      = 1'b1;
        dipsw_a      = 8'hFF;
        dipsw_b      = 8'hFF;
        dipsw_c      = 4'hF;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset state with bank 0
        check("irq_n", 32'(irq_n), 32'h1);
        check("nmi_n", 32'(nmi_n), 32'h1);
        check("snd_irq", 32'(snd_irq), 32'h0);
        check("snd_latch", 32'(snd_latch), 32'h0);
        check("cpu_din", 32'(cpu_din), 32'(open_bus));
        check("rom_addr", 32'(rom_addr), 32'h0123);

        for (int i = 0; i < n_ram; i++) begin
            ram_addrs.push_back(ram_aw'(rand_bits(ram_aw)));
            data = 8'(rand_bits(8));
            ram_model[ram_addrs[i]] = data;
            write_byte({4'h1, ram_addrs[i]}, data);
        end
        foreach (ram_addrs[i]) begin
            read_expect("cpu_din ram", {4'h1, ram_addrs[i]}, ram_model[ram_addrs[i]], 4'b0000);
        end

        gfx1_dout = 8'(rand_bits(8));
        gfx2_dout = 8'(rand_bits(8));
        pal_dout  = 8'(rand_bits(8));
        read_expect("cpu_din gfx1", 16'h2000 | 16'(rand_bits(13)), gfx1_dout, 4'b0100);
        read_expect("cpu_din gfx2", 16'h4000 | 16'(rand_bits(13)), gfx2_dout, 4'b0010);
        read_expect("cpu_din pal", 16'h0C00 | 16'(rand_bits(8)), pal_dout, 4'b0001);
        read_expect("cpu_din unmapped", 16'h0800 | 16'(rand_bits(8)), open_bus, 4'b0000);
        read_expect("cpu_din io none", 16'h0000, open_bus, 4'b0000);

        for (int i = 0; i < 3; i++) begin
            bank = 3'(rand_bits(3));
            off  = 16'(rand_bits(16));
            write_byte({8'h00, io_rom_bank}, {5'b00000, bank});
            rom_read({3'b011, off[12:0]}, 32'(bank) * 32'h2000 + 32'(off[12:0]));
            rom_read({1'b1, off[14:0]}, 32'(fixed_rom_base) + 32'(off[14:0]));
        end

        start_button = 2'(rand_bits(2));
        coin_input   = 2'(rand_bits(2));
        joystick1    = 6'(rand_bits(6));
        joystick2    = 6'(rand_bits(6));
        service      = 1'(rand_bits(1));
        dipsw_a      = 8'(rand_bits(8));
        dipsw_b      = 8'(rand_bits(8));
        dipsw_c      = 4'(rand_bits(4));
        read_expect("cpu_din coin", {8'h00, io_coin},
                    {2'b11, start_button, 2'b11, coin_input}, 4'b0000);
        read_expect("cpu_din joy1", {8'h00, io_joy1}, {2'b11, joystick1}, 4'b0000);
        read_expect("cpu_din joy2", {8'h00, io_joy2}, {2'b11, joystick2}, 4'b0000);
        read_expect("cpu_din dsw_a", {8'h00, io_dsw_a}, dipsw_a, 4'b0000);
        read_expect("cpu_din dsw_b", {8'h00, io_dsw_b}, dipsw_b, 4'b0000);
        read_expect("cpu_din dsw_c", {8'h00, io_dsw_c}, {3'b111, service, dipsw_c}, 4'b0000);

        data = 8'(rand_bits(8));
        write_byte({8'h00, io_snd_latch}, data);
        check("snd_latch", 32'(snd_latch), 32'(data));
        write_byte({8'h00, io_snd_irq}, 8'h00);
        check("snd_irq", 32'(snd_irq), 32'h1);
        @(posedge clk);
        #1;
        check("snd_irq", 32'(snd_irq), 32'h0);

        edge_latch_case(1'b0);
        edge_latch_case(1'b1);
        // Both request lines toggle with no effect while paused
        dip_pause = 1'b0;
        @(posedge clk);
        #1;
        gfx_irqn = 1'b0;
        gfx_nmin = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        check("irq_n paused", 32'(irq_n), 32'h1);
        check("nmi_n paused", 32'(nmi_n), 32'h1);
        gfx_irqn = 1'b1;
        gfx_nmin = 1'b1;
        repeat (2) @(posedge clk);
        #1;

        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
common/main_pkg.sv
common/cpu_bus_if.sv
source/main_irq.sv
main_decoder/main_decoder.sv
source/work_ram.sv
source/main_busmux.sv
source/main_board.sv
dv/tb_main_board.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it, exit status follows the test result

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_main_board -Mdir obj_dir -f sources.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/Vtb_main_board); then
    printf '%s\n' "$out"
    echo "Simulation exited with an error"
    exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1
